// File: verilog/tcp_tx_settings.svh
`ifndef TCP_TX_SETTINGS_SVH
`define TCP_TX_SETTINGS_SVH

// bytes the downstream takes before credit comes back
`define TX_CREDITS 4

// packed option area in 32-bit words
`define OPT_MAX_WORDS 10

// prototype words walked by the packer
`define OPT_SLOTS 15

`define SACK_MAX_BLOCKS 4

// payload address in the request and on the serializer read port
`define PAYLOAD_ADDR_W 16

// default depth of the payload RAM as an address width
`define PAYLOAD_AW_DEFAULT 10

`endif

// File: verilog/tcp_tx_pkg.sv
`include "tcp_tx_settings.svh"

package tcp_tx_pkg;

    // option kind bytes as they go on the wire
    localparam logic [7:0] TCP_OPT_NOP       = 8'd1;
    localparam logic [7:0] TCP_OPT_MSS       = 8'd2;
    localparam logic [7:0] TCP_OPT_WIN       = 8'd3;
    localparam logic [7:0] TCP_OPT_SACK_PERM = 8'd4;
    localparam logic [7:0] TCP_OPT_SACK      = 8'd5;
    localparam logic [7:0] TCP_OPT_TS        = 8'd8;

    // fixed header, offset and checksum filled in later
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [31:0] seq_num;
        logic [31:0] ack_num;
        logic [8:0]  flags;     // ns down to fin
        logic [15:0] win_size;
        logic [15:0] urg_ptr;
    } tcp_hdr_t;

    typedef struct packed {
        logic [31:0] left;
        logic [31:0] right;
    } tcp_sack_blk_t;

    typedef struct packed {
        logic                                  mss_pres;
        logic [15:0]                           mss;
        logic                                  win_pres;
        logic [7:0]                            win_scale;
        logic                                  sack_perm_pres;
        logic                                  sack_pres;
        logic [0:`SACK_MAX_BLOCKS-1]           blk_pres;   // per block
        tcp_sack_blk_t [0:`SACK_MAX_BLOCKS-1]  blk;
        logic                                  ts_pres;
        logic [31:0]                           ts_val;
        logic [31:0]                           ts_ecr;
    } tcp_opt_t;

    typedef struct packed {
        logic [31:0]                src_ip;
        logic [31:0]                dst_ip;
        tcp_hdr_t                   hdr;
        tcp_opt_t                   opt;
        logic [15:0]                payload_len;
        logic [31:0]                payload_chsum;   // supplied by requester
        logic [`PAYLOAD_ADDR_W-1:0] payload_addr;
    } tcp_tx_req_t;

    // decode output, word 0 goes out first
    typedef struct packed {
        tcp_tx_req_t                       req;
        logic [0:`OPT_MAX_WORDS-1][31:0]   opt_words;
        logic [3:0]                        opt_cnt;
        logic [3:0]                        data_offset;
    } tcp_seg_t;

    typedef struct packed {
        logic [7:0] data;
        logic       sof;
        logic       eof;
    } tcp_byte_t;

endpackage

// File: verilog/tcp_payload_ram.sv
module tcp_payload_ram #(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              ram_we,     // host side
    input  logic [ADDR_W-1:0] ram_waddr,
    input  logic [7:0]        ram_wdata,
    input  logic [ADDR_W-1:0] rd_addr,    // serializer side
    output logic [7:0]        rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    logic [7:0] mem [DEPTH];

    // host writes payload bytes before the request
    always_ff @(posedge clk) begin
        if (ram_we) mem[ram_waddr] <= ram_wdata;
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/tcp_opt_packer.sv
`include "tcp_tx_settings.svh"

module tcp_opt_packer (
    input  logic                   clk,
    input  logic                   fsm_rst,
    input  tcp_tx_pkg::tcp_tx_req_t req,
    input  logic                   req_v,
    input  logic                   seg_done,   // eof sent
    output tcp_tx_pkg::tcp_seg_t   seg,
    output logic                   seg_v,
    output logic                   busy
);

    localparam int TS_SLOT = 4 + 2 * `SACK_MAX_BLOCKS;   // kind word of timestamp

    logic [0:`OPT_SLOTS-1][31:0] proto_in, proto;
    logic [0:`OPT_SLOTS-1]       pres_in, pres;
    logic [7:0]                  sack_len;
    logic                        shifting;
    logic [3:0]                  slot_cnt;

    // every possible option laid out in slot order
    always_comb begin
        sack_len = 8'd2;                       // kind + length
        for (int b = 0; b < `SACK_MAX_BLOCKS; b++) begin
            if (req.opt.blk_pres[b]) sack_len = sack_len + 8'd8;
        end
        proto_in = '0;
        pres_in  = '0;
        proto_in[0] = {tcp_tx_pkg::TCP_OPT_MSS, 8'd4, req.opt.mss};
        pres_in[0]  = req.opt.mss_pres;
        proto_in[1] = {tcp_tx_pkg::TCP_OPT_NOP, tcp_tx_pkg::TCP_OPT_WIN, 8'd3,
                       req.opt.win_scale};
        pres_in[1]  = req.opt.win_pres;
        proto_in[2] = {tcp_tx_pkg::TCP_OPT_NOP, tcp_tx_pkg::TCP_OPT_NOP,
                       tcp_tx_pkg::TCP_OPT_SACK_PERM, 8'd2};
        pres_in[2]  = req.opt.sack_perm_pres;
        proto_in[3] = {tcp_tx_pkg::TCP_OPT_NOP, tcp_tx_pkg::TCP_OPT_NOP,
                       tcp_tx_pkg::TCP_OPT_SACK, sack_len};
        pres_in[3]  = req.opt.sack_pres;
        for (int b = 0; b < `SACK_MAX_BLOCKS; b++) begin
            proto_in[4 + 2 * b] = req.opt.blk[b].left;
            proto_in[5 + 2 * b] = req.opt.blk[b].right;
            pres_in[4 + 2 * b]  = req.opt.sack_pres && req.opt.blk_pres[b];
            pres_in[5 + 2 * b]  = req.opt.sack_pres && req.opt.blk_pres[b];
        end
        proto_in[TS_SLOT]     = {tcp_tx_pkg::TCP_OPT_NOP, tcp_tx_pkg::TCP_OPT_NOP,
                                 tcp_tx_pkg::TCP_OPT_TS, 8'd10};
        proto_in[TS_SLOT + 1] = req.opt.ts_val;
        proto_in[TS_SLOT + 2] = req.opt.ts_ecr;
        pres_in[TS_SLOT +: 3] = {3{req.opt.ts_pres}};
    end

    always_ff @(posedge clk) begin
        if (fsm_rst) begin
            busy     <= 1'b0;
            seg_v    <= 1'b0;
            shifting <= 1'b0;
            slot_cnt <= '0;
        end else begin
            seg_v <= 1'b0;
            if (req_v && !busy) begin           // take request
                busy            <= 1'b1;
                shifting        <= 1'b1;
                slot_cnt        <= '0;
                proto           <= proto_in;
                pres            <= pres_in;
                seg.req         <= req;
                seg.opt_words   <= '0;         // unused words stay zero for the checksum
                seg.opt_cnt     <= '0;
                seg.data_offset <= 4'd5;       // bare header
            end else if (seg_done) begin
                busy <= 1'b0;
            end
            if (shifting) begin                // one slot per cycle
                proto[0:`OPT_SLOTS-2] <= proto[1:`OPT_SLOTS-1];
                pres[0:`OPT_SLOTS-2]  <= pres[1:`OPT_SLOTS-1];
                slot_cnt              <= slot_cnt + 4'd1;
                if (pres[0]) begin             // append present word
                    seg.opt_words[seg.opt_cnt] <= proto[0];
                    seg.opt_cnt                <= seg.opt_cnt + 4'd1;
                    seg.data_offset            <= seg.data_offset + 4'd1;
                end
                if (slot_cnt == `OPT_SLOTS - 1) begin
                    shifting <= 1'b0;
                    seg_v    <= 1'b1;          // words complete
                end
            end
        end
    end

endmodule

// File: verilog/tcp_chsum_calc.sv
`include "tcp_tx_settings.svh"

module tcp_chsum_calc (
    input  logic                 clk,
    input  logic                 fsm_rst,
    input  tcp_tx_pkg::tcp_seg_t seg,
    input  logic                 seg_v,
    output logic [15:0]          chsum,
    output logic                 chsum_v
);

    localparam logic [7:0] IP_PROTO_TCP = 8'd6;
    localparam int         HC_WORDS     = 10 + 2 * `OPT_MAX_WORDS;   // header + options

    logic [0:5][15:0]          ph_sr;      // pseudo header
    logic [0:HC_WORDS-1][15:0] hc_sr;      // header and options
    logic [15:0]               tcp_len;
    logic [31:0]               ph_sum, hc_sum, carry;
    logic [16:0]               fold_sum;
    logic [3:0]                doff_q;
    logic [4:0]                cnt;
    logic                      calc, fold1, fold2;

    assign tcp_len = {10'd0, seg.data_offset, 2'b00} + seg.req.payload_len;

    always_ff @(posedge clk) begin
        if (fsm_rst) begin
            calc    <= 1'b0;
            fold1   <= 1'b0;
            fold2   <= 1'b0;
            chsum_v <= 1'b0;
            cnt     <= '0;
        end else begin
            chsum_v <= 1'b0;
            fold1   <= 1'b0;
            fold2   <= fold1;
            if (seg_v) begin
                ph_sr  <= {seg.req.src_ip, seg.req.dst_ip, 8'h00, IP_PROTO_TCP, tcp_len};
                hc_sr  <= {seg.req.hdr.src_port, seg.req.hdr.dst_port,
                           seg.req.hdr.seq_num, seg.req.hdr.ack_num,
                           seg.data_offset, 3'b000, seg.req.hdr.flags,
                           seg.req.hdr.win_size,
                           16'h0000,               // checksum field counts as zero
                           seg.req.hdr.urg_ptr, seg.opt_words};
                carry  <= seg.req.payload_chsum;   // start from payload sum
                ph_sum <= '0;
                hc_sum <= '0;
                doff_q <= seg.data_offset;
                cnt    <= '0;
                calc   <= 1'b1;
            end else if (calc) begin
                // both registers advance by one 16-bit word, zeros shift in
                ph_sr  <= {ph_sr[1:5], 16'h0000};
                hc_sr  <= {hc_sr[1:HC_WORDS-1], 16'h0000};
                ph_sum <= ph_sum + ph_sr[0];
                hc_sum <= hc_sum + hc_sr[0];
                cnt    <= cnt + 5'd1;
                if (cnt == 5'd6) begin
                    carry <= carry + ph_sum;          // all 6 pseudo words in
                end else if (cnt == {doff_q, 1'b0}) begin
                    carry <= carry + hc_sum;          // 2*doff header words in
                    calc  <= 1'b0;
                    fold1 <= 1'b1;
                end
            end
            if (fold1) fold_sum <= carry[31:16] + carry[15:0];   // first fold
            if (fold2) begin
                chsum   <= ~(fold_sum[15:0] + fold_sum[16]);     // end carry back in
                chsum_v <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/tcp_byte_serializer.sv
`include "tcp_tx_settings.svh"

module tcp_byte_serializer (
    input  logic                       clk,
    input  logic                       fsm_rst,
    input  tcp_tx_pkg::tcp_seg_t       seg,
    input  logic                       seg_v,
    input  logic [15:0]                chsum,
    input  logic                       chsum_v,
    input  logic                       credit_ret,
    output tcp_tx_pkg::tcp_byte_t      tx,
    output logic                       tx_v,
    output logic                       seg_done,
    output logic [`PAYLOAD_ADDR_W-1:0] rd_addr,
    input  logic [7:0]                 rd_data
);

    localparam int HDR_BYTES = 20 + 4 * `OPT_MAX_WORDS;
    localparam int CW        = $clog2(`TX_CREDITS + 1);

    tcp_tx_pkg::tcp_seg_t           seg_q;
    logic [0:HDR_BYTES-1][7:0]      hdr_sr;
    logic [`PAYLOAD_ADDR_W-1:0]     ptr;       // next payload byte
    logic [16:0]                    byte_cnt, total_len;
    logic [5:0]                     hdr_len;
    logic [CW-1:0]                  credits;
    logic [CW:0]                    avail;
    logic                           active, send, is_hdr, last;

    assign hdr_len   = {seg_q.data_offset, 2'b00};
    assign total_len = {11'd0, hdr_len} + {1'b0, seg_q.req.payload_len};
    assign is_hdr    = byte_cnt < {11'd0, hdr_len};
    assign last      = byte_cnt == total_len - 17'd1;

    // credit left after this cycle, a same-cycle return counts
    assign avail = {1'b0, credits} + (CW + 1)'(credit_ret) - (CW + 1)'(tx_v);
    assign send  = active && (avail != '0);

    // read one byte ahead, held while stalled
    assign rd_addr = (send && !is_hdr) ? ptr + 1'b1 : ptr;

    always_ff @(posedge clk) begin
        if (seg_v) seg_q <= seg;               // held until the next segment
        if (fsm_rst) begin
            active   <= 1'b0;
            tx_v     <= 1'b0;
            tx.sof   <= 1'b0;
            tx.eof   <= 1'b0;
            seg_done <= 1'b0;
            byte_cnt <= '0;
            ptr      <= '0;
            credits  <= CW'(`TX_CREDITS);
        end else begin
            credits  <= avail[CW-1:0];
            tx_v     <= send;
            tx.sof   <= send && (byte_cnt == '0);
            tx.eof   <= send && last;
            seg_done <= send && last;
            if (chsum_v) begin                 // header bytes in wire order
                active            <= 1'b1;
                byte_cnt          <= '0;
                ptr               <= seg_q.req.payload_addr;
                hdr_sr[0:1]       <= seg_q.req.hdr.src_port;
                hdr_sr[2:3]       <= seg_q.req.hdr.dst_port;
                hdr_sr[4:7]       <= seg_q.req.hdr.seq_num;
                hdr_sr[8:11]      <= seg_q.req.hdr.ack_num;
                hdr_sr[12]        <= {seg_q.data_offset, 3'b000, seg_q.req.hdr.flags[8]};
                hdr_sr[13]        <= seg_q.req.hdr.flags[7:0];
                hdr_sr[14:15]     <= seg_q.req.hdr.win_size;
                hdr_sr[16:17]     <= chsum;
                hdr_sr[18:19]     <= seg_q.req.hdr.urg_ptr;
                hdr_sr[20:HDR_BYTES-1] <= seg_q.opt_words;
            end else if (send) begin
                byte_cnt <= byte_cnt + 17'd1;
                if (is_hdr) begin
                    tx.data <= hdr_sr[0];
                    hdr_sr[0:HDR_BYTES-2] <= hdr_sr[1:HDR_BYTES-1];
                end else begin
                    tx.data <= rd_data;        // fetched on the previous beat
                    ptr     <= ptr + 1'b1;
                end
                if (last) active <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/tcp_tx_top.sv
`include "tcp_tx_settings.svh"

module tcp_tx_top #(
    parameter int ADDR_W = `PAYLOAD_AW_DEFAULT
) (
    input  logic                    clk,
    input  logic                    fsm_rst,
    input  tcp_tx_pkg::tcp_tx_req_t req,
    input  logic                    req_v,
    output logic                    busy,
    output tcp_tx_pkg::tcp_byte_t   tx,
    output logic                    tx_v,
    input  logic                    credit_ret,
    input  logic                    ram_we,
    input  logic [ADDR_W-1:0]       ram_waddr,
    input  logic [7:0]              ram_wdata
);

    tcp_tx_pkg::tcp_seg_t       seg;
    logic                       seg_v;
    logic [15:0]                chsum;
    logic                       chsum_v;
    logic                       seg_done;
    logic [`PAYLOAD_ADDR_W-1:0] rd_addr;   // RAM takes the low bits
    logic [7:0]                 rd_data;

    // decode
    tcp_opt_packer u_packer (
        .clk      (clk),
        .fsm_rst  (fsm_rst),
        .req      (req),
        .req_v    (req_v),
        .seg_done (seg_done),
        .seg      (seg),
        .seg_v    (seg_v),
        .busy     (busy)
    );

    // execute
    tcp_chsum_calc u_chsum (
        .clk     (clk),
        .fsm_rst (fsm_rst),
        .seg     (seg),
        .seg_v   (seg_v),
        .chsum   (chsum),
        .chsum_v (chsum_v)
    );

    // result
    tcp_byte_serializer u_ser (
        .clk        (clk),
        .fsm_rst    (fsm_rst),
        .seg        (seg),
        .seg_v      (seg_v),
        .chsum      (chsum),
        .chsum_v    (chsum_v),
        .credit_ret (credit_ret),
        .tx         (tx),
        .tx_v       (tx_v),
        .seg_done   (seg_done),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    tcp_payload_ram #(.ADDR_W(ADDR_W)) u_ram (
        .clk       (clk),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata),
        .rd_addr   (rd_addr[ADDR_W-1:0]),
        .rd_data   (rd_data)
    );

endmodule

// File: tb/tcp_tx_checker.sv
`include "tcp_tx_settings.svh"

module tcp_tx_checker (
    input logic                  clk,
    input logic                  fsm_rst,
    input logic                  busy,
    input tcp_tx_pkg::tcp_byte_t tx,
    input logic                  tx_v,
    input logic                  credit_ret
);
    timeunit 1ns;
    timeprecision 100ps;

    int   credits;   // mirror of the serializer counter
    logic in_seg;    // between sof and eof

    always @(posedge clk) begin
        if (fsm_rst) begin
            credits <= `TX_CREDITS;
            in_seg  <= 1'b0;
        end else begin
            credits <= credits + int'(credit_ret) - int'(tx_v);
            if (tx_v && tx.sof) in_seg <= 1'b1;
            if (tx_v && tx.eof) in_seg <= 1'b0;
        end
    end

    // a credit handed back in the same cycle may carry the beat
    credit_ok: assert property (@(posedge clk) disable iff (fsm_rst)
        tx_v |-> credits + int'(credit_ret) > 0) else $error("tx_v without credit");

    busy_hold: assert property (@(posedge clk) disable iff (fsm_rst)
        busy && !(tx_v && tx.eof) |=> busy) else $error("busy fell before eof");

    busy_release: assert property (@(posedge clk) disable iff (fsm_rst)
        tx_v && tx.eof |=> !busy) else $error("busy still high after eof");

    sof_first: assert property (@(posedge clk) disable iff (fsm_rst)
        tx_v && tx.sof |-> !in_seg) else $error("sof inside a segment");

    // eof and every later beat only after a sof
    mid_beat: assert property (@(posedge clk) disable iff (fsm_rst)
        tx_v && !tx.sof |-> in_seg) else $error("beat outside a segment");

    reset_quiet: assert property (@(posedge clk)
        fsm_rst |=> !tx_v && !busy) else $error("tx_v or busy high after reset");

endmodule

bind tcp_tx_top tcp_tx_checker u_checker (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .busy       (busy),
    .tx         (tx),
    .tx_v       (tx_v),
    .credit_ret (credit_ret)
);

// File: tb/tcp_tx_tb.sv
`include "tcp_tx_settings.svh"

module tcp_tx_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_SEGS    = 24;
    localparam int MAX_BYTES = 20 + 4 * `OPT_MAX_WORDS + 64;   // longest payload is 64
    localparam int WD_CYCLES = 1024 + (N_SEGS + 2) * (40 + 4 * MAX_BYTES);   // RAM fill first

    logic                    clk = 1'b0;
    logic                    fsm_rst, req_v, ram_we, busy, tx_v;
    logic                    credit_ret = 1'b0;
    logic [9:0]              ram_waddr;
    logic [7:0]              ram_wdata;
    tcp_tx_pkg::tcp_tx_req_t req;
    tcp_tx_pkg::tcp_byte_t   tx;
    logic [7:0]              ram_img [1024];   // what the host wrote
    logic [9:0]              exp_q [$];        // {data, sof, eof} in wire order
    logic [9:0]              exp_beat;
    int                      seed     = 32'he1c7_6097;
    int                      errors   = 0;
    int                      owed     = 0;     // beats not yet credited back
    int                      ret_odds = 8;     // credit return chance in eighths

    tcp_tx_top UUT (.*);

    always #4 clk = ~clk;

    // random request with options trimmed to at most 10 words
    function automatic tcp_tx_pkg::tcp_tx_req_t random_req(input int s);
        logic [$bits(tcp_tx_pkg::tcp_tx_req_t)+31:0] bits;
        tcp_tx_pkg::tcp_tx_req_t                     r;
        for (int i = 0; i < $bits(bits) / 32; i++) begin
            bits = {bits[$bits(bits)-33:0], 32'($random(seed))};
        end
        r = bits[$bits(r)-1:0];
        if (r.opt.ts_pres) r.opt.blk_pres[1:3] = '0;        // 9 words at most
        else if (r.opt.mss_pres || r.opt.win_pres) r.opt.blk_pres[3] = 1'b0;
        if (s == 0) r.opt = '0;                             // bare header
        r.payload_len   = (s == 1) ? 16'd0 : 16'($unsigned($random(seed)) % 65);
        r.payload_chsum = {16'h0000, r.payload_chsum[15:0]};   // already folded
        return r;
    endfunction

    // reference model of the wire bytes
    function automatic void expect_segment(input tcp_tx_pkg::tcp_tx_req_t r);
        logic [31:0]  w [$];
        logic [7:0]   b [$];
        logic [159:0] hdr;
        logic [31:0]  sum;
        logic [3:0]   doff;
        int           nblk;
        nblk = 0;
        if (r.opt.mss_pres) w.push_back({tcp_tx_pkg::TCP_OPT_MSS, 8'd4, r.opt.mss});
        if (r.opt.win_pres)
            w.push_back({tcp_tx_pkg::TCP_OPT_NOP, tcp_tx_pkg::TCP_OPT_WIN, 8'd3, r.opt.win_scale});
        if (r.opt.sack_perm_pres)
            w.push_back({{2{tcp_tx_pkg::TCP_OPT_NOP}}, tcp_tx_pkg::TCP_OPT_SACK_PERM, 8'd2});
        if (r.opt.sack_pres) begin
            for (int i = 0; i < `SACK_MAX_BLOCKS; i++) nblk += int'(r.opt.blk_pres[i]);
            w.push_back({{2{tcp_tx_pkg::TCP_OPT_NOP}}, tcp_tx_pkg::TCP_OPT_SACK, 8'(2 + 8 * nblk)});
            for (int i = 0; i < `SACK_MAX_BLOCKS; i++) begin
                if (r.opt.blk_pres[i]) begin
                    w.push_back(r.opt.blk[i].left);
                    w.push_back(r.opt.blk[i].right);
                end
            end
        end
        if (r.opt.ts_pres) begin
            w.push_back({{2{tcp_tx_pkg::TCP_OPT_NOP}}, tcp_tx_pkg::TCP_OPT_TS, 8'd10});
            w.push_back(r.opt.ts_val);
            w.push_back(r.opt.ts_ecr);
        end
        doff = 4'(5 + w.size());
        hdr  = {r.hdr.src_port, r.hdr.dst_port, r.hdr.seq_num, r.hdr.ack_num, doff, 3'b000,
                r.hdr.flags, r.hdr.win_size, 16'h0000, r.hdr.urg_ptr};
        for (int i = 19; i >= 0; i--) b.push_back(hdr[8*i +: 8]);
        foreach (w[i]) for (int k = 3; k >= 0; k--) b.push_back(w[i][8*k +: 8]);
        // pseudo header words, then header and options
        sum = r.payload_chsum + r.src_ip[31:16] + r.src_ip[15:0] + r.dst_ip[31:16]
              + r.dst_ip[15:0] + 32'd6 + 32'({doff, 2'b00}) + r.payload_len;
        for (int i = 0; i < b.size(); i += 2) sum += {b[i], b[i+1]};
        while (sum[31:16] != 16'h0000) sum = sum[31:16] + sum[15:0];
        b[16] = ~sum[15:8];
        b[17] = ~sum[7:0];
        for (int i = 0; i < r.payload_len; i++) b.push_back(ram_img[10'(r.payload_addr + i)]);
        foreach (b[i]) exp_q.push_back({b[i], i == 0, i == b.size() - 1});
    endfunction

    // req_v stays high until the DUT takes the request
    task automatic send(input tcp_tx_pkg::tcp_tx_req_t r);
        req   = r;
        req_v = 1'b1;
        while (busy) @(negedge clk);
        @(negedge clk);                    // taken on the rising edge just passed
        req_v = 1'b0;
        expect_segment(r);
    endtask

    // downstream sink compares each beat and hands credit back at random
    always @(negedge clk) begin
        credit_ret = 1'b0;
        if (fsm_rst) begin
            owed = 0;                      // counter reloads in reset
        end else begin
            if (tx_v) begin
                owed++;
                assert (exp_q.size() > 0) else begin
                    $display("[%0t] beat arrived with no segment outstanding", $time);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_beat = exp_q.pop_front();
                    assert (tx === exp_beat) else begin
                        $display("FAILED at %0t: tx expected %h got %h", $time, exp_beat, tx);
                        errors++;
                    end
                end
            end
            if (owed > 0 && $unsigned($random(seed)) % 8 < ret_odds) begin
                credit_ret = 1'b1;
                owed--;
            end
            // a credit handed back in the same cycle may carry the beat
            assert (owed <= `TX_CREDITS) else begin
                $display("[%0t] beat sent with no credit left", $time);
                errors++;
            end
        end
    end

    initial begin
        #(WD_CYCLES * 8);
        $display("timeout after %0d cycles with %0d beats missing", WD_CYCLES, exp_q.size());
        $display("closing: %0d errors", errors);
        $display("Regression failed");
        $finish;
    end

    initial begin
        fsm_rst   = 1'b1;
        req_v     = 1'b0;
        req       = '0;
        ram_we    = 1'b0;
        ram_waddr = '0;
        ram_wdata = '0;
        repeat (4) @(negedge clk);
        fsm_rst = 1'b0;
        for (int a = 0; a < 1024; a++) begin      // host fills the payload RAM
            ram_img[a] = 8'(a) ^ 8'(a >> 8) ^ 8'($random(seed));
            ram_we     = 1'b1;
            ram_waddr  = 10'(a);
            ram_wdata  = ram_img[a];
            @(negedge clk);
        end
        ram_we = 1'b0;
        for (int s = 0; s < N_SEGS; s++) begin
            ret_odds = (s < N_SEGS / 2) ? 8 : 3;   // second half under back-pressure
            send(random_req(s));
        end
        send(random_req(N_SEGS));
        while (!tx_v) @(negedge clk);              // segment on the wire
        fsm_rst = 1'b1;                            // second reset in mid-segment
        exp_q.delete();                            // its remaining beats are dropped
        repeat (4) @(negedge clk);
        fsm_rst = 1'b0;
        assert (!tx_v && !busy) else begin
            $display("[%0t] tx_v or busy still high after reset", $time);
            errors++;
        end
        send(random_req(N_SEGS + 1));
        while (exp_q.size() > 0 || busy) @(negedge clk);
        $display("closing: %0d errors over %0d segments", errors, N_SEGS + 2);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tcp_tx_top.f
+incdir+verilog
verilog/tcp_tx_pkg.sv
verilog/tcp_payload_ram.sv
verilog/tcp_opt_packer.sv
verilog/tcp_chsum_calc.sv
verilog/tcp_byte_serializer.sv
verilog/tcp_tx_top.sv
tb/tcp_tx_checker.sv
tb/tcp_tx_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tcp_tx_tb -f tcp_tx_top.f
	./obj_dir/Vtcp_tx_tb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Regression failed" sim.log

clean:
	rm -rf obj_dir sim.log
